/* Makefile */
TOP = tb_cu_vertex_pagerank

all: run

build:
	verilator --binary --timing -f flist.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "^test passed$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module cu_vertex_pagerank

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* flist.f */
+incdir+tb
src/pagerank_pkg.sv
src/fifo.sv
src/command_arbiter.sv
src/edge_job_control.sv
src/edge_data_control.sv
src/sum_kernel.sv
src/cu_vertex_pagerank.sv
tb/tb_cu_vertex_pagerank.sv

/* src/command_arbiter.sv */
// Round-robin merge of the edge job and edge data read queues into the burst command buffer
module command_arbiter import pagerank_pkg::*; (
	input  logic          clock,
	input  logic          rstn,
	input  logic          enabled,
	input  read_command_t job_command,
	input  read_command_t data_command,
	input  logic          read_buffer_alfull,
	output logic          job_alfull,
	output logic          data_alfull,
	output read_command_t read_command
);

	read_command_t job_queue_out;
	read_command_t data_queue_out;
	read_command_t burst_in;
	logic          job_valid;
	logic          data_valid;
	logic          job_empty;
	logic          data_empty;
	logic          burst_alfull;
	logic          burst_empty;
	logic          job_grant;
	logic          data_grant;
	logic          burst_pop;
	logic          rr_ptr;

	fifo #(
		.WIDTH   ($bits(read_command_t)),
		.DEPTH   (CMD_BUF_DEPTH),
		.HEADROOM(ALFULL_HEADROOM)
	) job_queue (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_command.valid && enabled),
		.data_in (job_command),
		.pop     (job_grant),
		.data_out(job_queue_out),
		.valid   (job_valid),
		.full    (),
		.alfull  (job_alfull),
		.empty   (job_empty)
	);

	fifo #(
		.WIDTH   ($bits(read_command_t)),
		.DEPTH   (CMD_BUF_DEPTH),
		.HEADROOM(ALFULL_HEADROOM)
	) data_queue (
		.clock   (clock),
		.rstn    (rstn),
		.push    (data_command.valid && enabled),
		.data_in (data_command),
		.pop     (data_grant),
		.data_out(data_queue_out),
		.valid   (data_valid),
		.full    (),
		.alfull  (data_alfull),
		.empty   (data_empty)
	);

	////////////////////////////////////////////////////////////////////////////
	// Grant selection
	////////////////////////////////////////////////////////////////////////////

	// rr_ptr low favours the job queue when both hold commands
	always_comb begin
		job_grant  = 1'b0;
		data_grant = 1'b0;
		if (enabled && !burst_alfull) begin
			if (!job_empty && (data_empty || !rr_ptr)) begin
				job_grant = 1'b1;
			end else if (!data_empty) begin
				data_grant = 1'b1;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rr_ptr <= 1'b0;
		end else if (job_grant || data_grant) begin
			rr_ptr <= job_grant;
		end
	end

	// At most one queue pops per cycle
	assign burst_in  = job_valid ? job_queue_out : data_queue_out;
	assign burst_pop = enabled && !burst_empty && !read_buffer_alfull;

	fifo #(
		.WIDTH   ($bits(read_command_t)),
		.DEPTH   (BURST_BUF_DEPTH),
		.HEADROOM(ALFULL_HEADROOM)
	) burst_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_valid || data_valid),
		.data_in (burst_in),
		.pop     (burst_pop),
		.data_out(read_command),
		.valid   (),
		.full    (),
		.alfull  (burst_alfull),
		.empty   (burst_empty)
	);

endmodule

/* src/cu_vertex_pagerank.sv */
// PageRank vertex compute unit top, vertex jobs in, tagged reads out, vertex sums written back
module cu_vertex_pagerank import pagerank_pkg::*; (
	input  logic          clock,
	input  logic          rstn,
	input  logic          enabled_in,
	input  vertex_job_t   vertex_job,
	input  read_data_t    read_data_in,
	input  logic          read_buffer_alfull,
	input  logic          write_buffer_alfull,
	output read_command_t read_command_out,
	output write_line_t   write_out,
	output vertex_t       vertex_num_counter,
	output edge_t         edge_num_counter
);

	logic          enabled;
	vertex_job_t   vertex_job_q;
	read_data_t    read_data_q;
	logic          read_alfull_q;
	logic          write_alfull_q;
	read_data_t    edge_data;
	read_data_t    graph_data;
	vertex_job_t   vertex_buf_out;
	logic          vertex_buf_valid;
	logic          vertex_buf_empty;
	logic          vertex_buf_pop;
	vertex_job_t   vertex_job_latched;
	read_command_t job_command;
	read_command_t data_command;
	read_command_t read_command;
	logic          job_alfull;
	write_line_t   write_line;
	write_line_t   write_buf_out;
	logic          write_buf_empty;
	logic          write_buf_alfull;
	logic          write_buf_pop;
	logic          vertex_done;
	edge_t         edges_summed;

	////////////////////////////////////////////////////////////////////////////
	// Enable, input latches and tag routing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled        <= 1'b0;
			vertex_job_q   <= '0;
			read_data_q    <= '0;
			read_alfull_q  <= 1'b0;
			write_alfull_q <= 1'b0;
			edge_data      <= '0;
			graph_data     <= '0;
		end else begin
			enabled        <= enabled_in;
			vertex_job_q   <= vertex_job;
			read_data_q    <= read_data_in;
			read_alfull_q  <= read_buffer_alfull;
			write_alfull_q <= write_buffer_alfull;
			edge_data      <= '0;
			graph_data     <= '0;
			// Untagged data goes nowhere
			if (read_data_q.valid) begin
				case (read_data_q.array)
					EDGE_ARRAY: edge_data  <= read_data_q;
					GRAPH_DATA: graph_data <= read_data_q;
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Vertex job buffer and latch
	////////////////////////////////////////////////////////////////////////////

	// Hold off while a popped job is still on its way to the latch
	assign vertex_buf_pop = enabled && !vertex_buf_empty && !vertex_job_latched.valid &&
		!vertex_buf_valid && !write_buf_alfull;

	fifo #(
		.WIDTH   ($bits(vertex_job_t)),
		.DEPTH   (VERTEX_BUF_DEPTH),
		.HEADROOM(ALFULL_HEADROOM)
	) vertex_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (vertex_job_q.valid),
		.data_in (vertex_job_q),
		.pop     (vertex_buf_pop),
		.data_out(vertex_buf_out),
		.valid   (vertex_buf_valid),
		.full    (),
		.alfull  (),
		.empty   (vertex_buf_empty)
	);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_job_latched <= '0;
		end else if (enabled) begin
			if (vertex_done) begin
				vertex_job_latched <= '0;
			end else if (vertex_buf_out.valid) begin
				vertex_job_latched <= vertex_buf_out;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compute blocks
	////////////////////////////////////////////////////////////////////////////

	edge_job_control u_edge_job_control (
		.clock       (clock),
		.rstn        (rstn),
		.enabled     (enabled),
		.vertex_job  (vertex_job_latched),
		.queue_alfull(job_alfull),
		.command     (job_command)
	);

	edge_data_control u_edge_data_control (
		.clock    (clock),
		.rstn     (rstn),
		.enabled  (enabled),
		.edge_data(edge_data),
		.command  (data_command)
	);

	command_arbiter u_command_arbiter (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.job_command       (job_command),
		.data_command      (data_command),
		.read_buffer_alfull(read_alfull_q),
		.job_alfull        (job_alfull),
		.data_alfull       (),
		.read_command      (read_command)
	);

	sum_kernel u_sum_kernel (
		.clock       (clock),
		.rstn        (rstn),
		.enabled     (enabled),
		.vertex_job  (vertex_job_latched),
		.graph_data  (graph_data),
		.write_line  (write_line),
		.vertex_done (vertex_done),
		.edges_summed(edges_summed)
	);

	////////////////////////////////////////////////////////////////////////////
	// Write buffer, outputs and counters
	////////////////////////////////////////////////////////////////////////////

	assign write_buf_pop = enabled && !write_buf_empty && !write_alfull_q;

	fifo #(
		.WIDTH   ($bits(write_line_t)),
		.DEPTH   (WRITE_BUF_DEPTH),
		.HEADROOM(ALFULL_HEADROOM)
	) write_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (write_line.valid && enabled),
		.data_in (write_line),
		.pop     (write_buf_pop),
		.data_out(write_buf_out),
		.valid   (),
		.full    (),
		.alfull  (write_buf_alfull),
		.empty   (write_buf_empty)
	);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_out   <= '0;
			write_out          <= '0;
			vertex_num_counter <= '0;
			edge_num_counter   <= '0;
		end else begin
			read_command_out <= read_command;
			write_out        <= write_buf_out;
			if (enabled) begin
				edge_num_counter <= edges_summed;
				if (vertex_done) begin
					vertex_num_counter <= vertex_num_counter + 1'b1;
				end
			end
		end
	end

endmodule

/* src/edge_data_control.sv */
// Graph data read issue for every destination id returned from the edge array
module edge_data_control import pagerank_pkg::*; (
	input  logic          clock,
	input  logic          rstn,
	input  logic          enabled,
	input  read_data_t    edge_data,
	output read_command_t command
);

	vertex_t dest_id;

	// Destination id lives in the low half of the returned word
	assign dest_id = edge_data.data[15:0];

	// No stall here, the queue headroom absorbs the one cycle of latency
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			command <= '0;
		end else if (enabled) begin
			if (edge_data.valid) begin
				command.valid   <= 1'b1;
				command.array   <= GRAPH_DATA;
				command.address <= dest_id;
			end else begin
				command <= '0;
			end
		end
	end

endmodule

/* src/edge_job_control.sv */
// Edge array read issue, one command per edge of the latched vertex
module edge_job_control import pagerank_pkg::*; (
	input  logic          clock,
	input  logic          rstn,
	input  logic          enabled,
	input  vertex_job_t   vertex_job,
	input  logic          queue_alfull,
	output read_command_t command
);

	job_state_e state;
	edge_t      issued;
	logic       served;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state   <= JOB_IDLE;
			issued  <= '0;
			served  <= 1'b0;
			command <= '0;
		end else if (enabled) begin
			command <= '0;
			// Ready for the next vertex once the latch drops
			if (!vertex_job.valid) begin
				served <= 1'b0;
			end
			case (state)
				JOB_IDLE: begin
					if (vertex_job.valid && !served) begin
						served <= 1'b1;
						issued <= '0;
						if (vertex_job.out_degree != 0) begin
							state <= JOB_ISSUE;
						end
					end
				end
				JOB_ISSUE: begin
					if (!queue_alfull) begin
						command.valid   <= 1'b1;
						command.array   <= EDGE_ARRAY;
						command.address <= vertex_job.edge_start + issued;
						issued          <= issued + 1'b1;
						if (issued + 1'b1 == vertex_job.out_degree) begin
							state <= JOB_IDLE;
						end
					end
				end
				default: state <= JOB_IDLE;
			endcase
		end
	end

endmodule

/* src/fifo.sv */
// Synchronous FIFO with count based full, almost-full and empty flags and registered read
module fifo #(
	parameter int WIDTH    = 8,
	parameter int DEPTH    = 16,
	parameter int HEADROOM = 2
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             valid,
	output logic             full,
	output logic             alfull,
	output logic             empty
);

	logic [WIDTH-1:0]           mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic                       do_push;
	logic                       do_pop;

	assign full    = (count == DEPTH);
	assign alfull  = (count >= DEPTH - HEADROOM);
	assign empty   = (count == 0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			data_out <= '0;
			valid    <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// Output is zero between pops so a line valid bit never repeats
			data_out <= do_pop ? mem[rd_ptr] : '0;
			valid    <= do_pop;
		end
	end

endmodule

/* src/pagerank_pkg.sv */
// PageRank vertex compute unit shared types, buffer sizes, array tags and line formats
package pagerank_pkg;

	// Widths that carry a meaning
	typedef logic [15:0] vertex_t;
	typedef logic [15:0] edge_t;
	typedef logic [15:0] addr_t;
	typedef logic [31:0] value_t;

	// Buffer sizing
	localparam int VERTEX_BUF_DEPTH = 16;
	localparam int CMD_BUF_DEPTH    = 8;
	localparam int BURST_BUF_DEPTH  = 16;
	localparam int WRITE_BUF_DEPTH  = 8;
	localparam int ALFULL_HEADROOM  = 2;

	// Tag carried by every read command and returned with its data
	typedef enum logic [1:0] {
		ARRAY_NONE,
		EDGE_ARRAY,
		GRAPH_DATA
	} array_e;

	typedef enum logic {
		JOB_IDLE,
		JOB_ISSUE
	} job_state_e;

	typedef enum logic [1:0] {
		SUM_IDLE,
		SUM_ACCUM,
		SUM_EMIT
	} sum_state_e;

	typedef struct packed {
		logic    valid;
		vertex_t id;
		addr_t   edge_start;
		edge_t   out_degree;
	} vertex_job_t;

	typedef struct packed {
		logic   valid;
		array_e array;
		addr_t  address;
	} read_command_t;

	// Edge entries sit in the low 16 bits of data
	typedef struct packed {
		logic   valid;
		array_e array;
		value_t data;
	} read_data_t;

	typedef struct packed {
		logic    valid;
		vertex_t id;
		value_t  sum;
	} write_line_t;

endpackage

/* src/sum_kernel.sv */
// Graph value accumulator for the latched vertex, emits one result line per vertex
module sum_kernel import pagerank_pkg::*; (
	input  logic        clock,
	input  logic        rstn,
	input  logic        enabled,
	input  vertex_job_t vertex_job,
	input  read_data_t  graph_data,
	output write_line_t write_line,
	output logic        vertex_done,
	output edge_t       edges_summed
);

	sum_state_e state;
	value_t     sum;
	edge_t      count;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state        <= SUM_IDLE;
			sum          <= '0;
			count        <= '0;
			edges_summed <= '0;
			write_line   <= '0;
			vertex_done  <= 1'b0;
		end else if (enabled) begin
			write_line  <= '0;
			vertex_done <= 1'b0;
			case (state)
				SUM_IDLE: begin
					if (vertex_job.valid) begin
						sum   <= '0;
						count <= '0;
						state <= SUM_ACCUM;
					end
				end
				SUM_ACCUM: begin
					if (count == vertex_job.out_degree) begin
						write_line.valid <= 1'b1;
						write_line.id    <= vertex_job.id;
						write_line.sum   <= sum;
						vertex_done      <= 1'b1;
						state            <= SUM_EMIT;
					end else if (graph_data.valid) begin
						sum          <= sum + graph_data.data;
						count        <= count + 1'b1;
						edges_summed <= edges_summed + 1'b1;
					end
				end
				// Latch clears at the end of this cycle
				SUM_EMIT: state <= SUM_IDLE;
				default: state <= SUM_IDLE;
			endcase
		end
	end

endmodule

/* tb/tb_tasks.svh */
// Testbench helpers for the vertex unit: random source, memory answers, checks and tests
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Fibonacci LFSR x^16 + x^14 + x^13 + x^11
function automatic logic [31:0] random_bits(input int count);
	logic [31:0] bits;
	logic        feedback;
	bits = '0;
	for (int i = 0; i < count; i++) begin
		feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr     = {lfsr[14:0], feedback};
		bits     = {bits[30:0], feedback};
	end
	return bits;
endfunction

task automatic fill_memories();
	for (int a = 0; a < MEM_SIZE; a++) begin
		edge_mem[a]  = vertex_t'(random_bits(8));
		value_mem[a] = random_bits(16);
	end
endtask

function automatic value_t answer_read(input read_command_t cmd);
	value_t word;
	word = '0;
	if (cmd.array == EDGE_ARRAY) begin
		word = {16'h0000, edge_mem[cmd.address[7:0]]};
	end else if (cmd.array == GRAPH_DATA) begin
		word = value_mem[cmd.address[7:0]];
	end
	return word;
endfunction

// Sum of graph values over the destinations of one edge list
function automatic value_t expected_sum(input addr_t start, input edge_t degree);
	value_t total;
	total = '0;
	for (int i = 0; i < int'(degree); i++) begin
		total = total + value_mem[edge_mem[int'(start) + i][7:0]];
	end
	return total;
endfunction

task automatic report_failure(input string reason);
	$display("%s", reason);
	$display("test failed");
	$fatal(1, "stopped at the first error");
endtask

task automatic check_vertex(input string name, input vertex_t actual, input vertex_t expected);
	if (actual !== expected) begin
		report_failure($sformatf("FAILED at %0t: %s = %0h, expected %0h",
			$time, name, actual, expected));
	end
endtask

task automatic check_value(input string name, input value_t actual, input value_t expected);
	if (actual !== expected) begin
		report_failure($sformatf("FAILED at %0t: %s = %0h, expected %0h",
			$time, name, actual, expected));
	end
endtask

task automatic check_edge(input string name, input edge_t actual, input edge_t expected);
	if (actual !== expected) begin
		report_failure($sformatf("FAILED at %0t: %s = %0h, expected %0h",
			$time, name, actual, expected));
	end
endtask

task automatic idle_cycles(input int cycles);
	repeat (cycles) @(posedge clock);
endtask

task automatic send_job(input vertex_t id, input addr_t start, input edge_t degree);
	@(negedge clock);
	vertex_job.valid      = 1'b1;
	vertex_job.id         = id;
	vertex_job.edge_start = start;
	vertex_job.out_degree = degree;
endtask

task automatic release_job();
	@(negedge clock);
	vertex_job = '0;
endtask

task automatic wait_writes(input int count);
	while (writes_seen.size() < count) begin
		@(posedge clock);
	end
endtask

task automatic check_next_write(input vertex_t id, input value_t sum);
	check_vertex("write_out.id", writes_seen[writes_checked].id, id);
	check_value("write_out.sum", writes_seen[writes_checked].sum, sum);
	writes_checked = writes_checked + 1;
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic single_vertex_sum();
	send_job(16'h0011, 16'd10, 16'd5);
	release_job();
	wait_writes(writes_checked + 1);
	check_next_write(16'h0011, expected_sum(16'd10, 16'd5));
endtask

task automatic zero_degree_vertex();
	edge_t edges_before;
	@(negedge clock);
	edges_before = edge_num_counter;
	send_job(16'h0022, 16'd50, 16'd0);
	release_job();
	wait_writes(writes_checked + 1);
	check_next_write(16'h0022, '0);
	@(negedge clock);
	check_edge("edge_num_counter", edge_num_counter, edges_before);
endtask

task automatic back_to_back_jobs();
	edge_t   degrees [8] = '{16'd3, 16'd1, 16'd4, 16'd1, 16'd5, 16'd2, 16'd6, 16'd2};
	vertex_t vertices_before;
	edge_t   edges_before;
	edge_t   total_degree;
	@(negedge clock);
	vertices_before = vertex_num_counter;
	edges_before    = edge_num_counter;
	total_degree    = '0;
	for (int i = 0; i < 8; i++) begin
		send_job(vertex_t'(16'h0100 + i), addr_t'(20 + 8 * i), degrees[i]);
		total_degree = total_degree + degrees[i];
	end
	release_job();
	wait_writes(writes_checked + 8);
	for (int i = 0; i < 8; i++) begin
		check_next_write(vertex_t'(16'h0100 + i), expected_sum(addr_t'(20 + 8 * i), degrees[i]));
	end
	@(negedge clock);
	check_vertex("vertex_num_counter", vertex_num_counter, vertices_before + 16'd8);
	check_edge("edge_num_counter", edge_num_counter, edges_before + total_degree);
endtask

task automatic read_backpressure();
	@(negedge clock);
	read_buffer_alfull = 1'b1;
	// Commands already in the output registers may still leave for two cycles
	idle_cycles(3);
	read_blocked = 1'b1;
	send_job(16'h0033, 16'd100, 16'd6);
	release_job();
	idle_cycles(40);
	if (writes_seen.size() != writes_checked) begin
		report_failure("a write line came out while read commands were held back");
	end
	read_blocked = 1'b0;
	@(negedge clock);
	read_buffer_alfull = 1'b0;
	wait_writes(writes_checked + 1);
	check_next_write(16'h0033, expected_sum(16'd100, 16'd6));
endtask

task automatic write_backpressure();
	@(negedge clock);
	write_buffer_alfull = 1'b1;
	idle_cycles(3);
	write_blocked = 1'b1;
	send_job(16'h0040, 16'd120, 16'd3);
	send_job(16'h0041, 16'd130, 16'd4);
	send_job(16'h0042, 16'd140, 16'd2);
	release_job();
	idle_cycles(150);
	write_blocked = 1'b0;
	@(negedge clock);
	write_buffer_alfull = 1'b0;
	wait_writes(writes_checked + 3);
	check_next_write(16'h0040, expected_sum(16'd120, 16'd3));
	check_next_write(16'h0041, expected_sum(16'd130, 16'd4));
	check_next_write(16'h0042, expected_sum(16'd140, 16'd2));
endtask

task automatic enable_and_tag_filter();
	vertex_t vertices_before;
	edge_t   edges_before;
	@(negedge clock);
	enabled_in = 1'b0;
	idle_cycles(3);
	@(negedge clock);
	vertices_before = vertex_num_counter;
	edges_before    = edge_num_counter;
	send_job(16'h0055, 16'd160, 16'd4);
	release_job();
	idle_cycles(30);
	@(negedge clock);
	check_vertex("vertex_num_counter", vertex_num_counter, vertices_before);
	check_edge("edge_num_counter", edge_num_counter, edges_before);
	if (writes_seen.size() != writes_checked) begin
		report_failure("a write line came out while the unit was disabled");
	end
	enabled_in = 1'b1;
	idle_cycles(4);
	// Untagged words arrive while the vertex is being summed
	inject_target = 6;
	wait_writes(writes_checked + 1);
	check_next_write(16'h0055, expected_sum(16'd160, 16'd4));
	@(negedge clock);
	check_vertex("vertex_num_counter", vertex_num_counter, vertices_before + 16'd1);
	check_edge("edge_num_counter", edge_num_counter, edges_before + 16'd4);
endtask

`endif

/* tb/tb_cu_vertex_pagerank.sv */
// Testbench for the PageRank vertex compute unit with a tagged read memory model
module tb_cu_vertex_pagerank import pagerank_pkg::*; ();

	localparam int MEM_SIZE    = 256;
	// Degrees over all tests: 5, 0, 24 in the burst, 6, 9 and 4
	localparam int TOTAL_EDGES = 48;
	localparam int CYCLE_LIMIT = 40 * TOTAL_EDGES + 2000;

	logic          clock = 1'b0;
	logic          rstn;
	logic          enabled_in;
	vertex_job_t   vertex_job;
	read_data_t    read_data_in;
	logic          read_buffer_alfull;
	logic          write_buffer_alfull;
	read_command_t read_command_out;
	write_line_t   write_out;
	vertex_t       vertex_num_counter;
	edge_t         edge_num_counter;

	// Memory model state and captured results
	logic [15:0]   lfsr;
	vertex_t       edge_mem [MEM_SIZE];
	value_t        value_mem [MEM_SIZE];
	read_command_t pending_cmd [$];
	int            pending_due [$];
	write_line_t   writes_seen [$];
	int            writes_checked;
	int            injected;
	int            inject_target;
	logic          read_blocked;
	logic          write_blocked;
	int            cycle_count = 0;

	`include "tb_tasks.svh"

	cu_vertex_pagerank UUT (
		.clock              (clock),
		.rstn               (rstn),
		.enabled_in         (enabled_in),
		.vertex_job         (vertex_job),
		.read_data_in       (read_data_in),
		.read_buffer_alfull (read_buffer_alfull),
		.write_buffer_alfull(write_buffer_alfull),
		.read_command_out   (read_command_out),
		.write_out          (write_out),
		.vertex_num_counter (vertex_num_counter),
		.edge_num_counter   (edge_num_counter)
	);

	always #50 clock = ~clock;

	always @(posedge clock) begin
		if (cycle_count >= CYCLE_LIMIT) begin
			report_failure("timeout: the run did not finish within its cycle limit");
		end else begin
			cycle_count <= cycle_count + 1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory model, answers reads in order after 0 to 3 cycles
	////////////////////////////////////////////////////////////////////////////

	initial begin : memory_model
		read_command_t cmd;
		lfsr         = 16'd42;
		injected     = 0;
		read_data_in = '0;
		fill_memories();
		forever begin
			@(negedge clock);
			if (read_command_out.valid && read_blocked) begin
				report_failure("read command issued while the host read buffer was almost full");
			end else if (write_out.valid && write_blocked) begin
				report_failure("write line issued while the host write buffer was almost full");
			end else begin
				if (read_command_out.valid) begin
					pending_cmd.push_back(read_command_out);
					pending_due.push_back(cycle_count + int'(random_bits(2)));
				end
				if (write_out.valid) begin
					writes_seen.push_back(write_out);
				end
				read_data_in = '0;
				if (pending_due.size() > 0 && pending_due[0] <= cycle_count) begin
					cmd = pending_cmd.pop_front();
					void'(pending_due.pop_front());
					read_data_in.valid = 1'b1;
					read_data_in.array = cmd.array;
					read_data_in.data  = answer_read(cmd);
				end else if (injected < inject_target) begin
					// Stray untagged word
					read_data_in.valid = 1'b1;
					read_data_in.array = ARRAY_NONE;
					read_data_in.data  = random_bits(32);
					injected           = injected + 1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		rstn                = 1'b0;
		enabled_in          = 1'b0;
		vertex_job          = '0;
		read_buffer_alfull  = 1'b0;
		write_buffer_alfull = 1'b0;
		writes_checked      = 0;
		inject_target       = 0;
		read_blocked        = 1'b0;
		write_blocked       = 1'b0;
		repeat (16) @(negedge clock);
		rstn       = 1'b1;
		enabled_in = 1'b1;
		repeat (4) @(negedge clock);
		single_vertex_sum();
		zero_degree_vertex();
		back_to_back_jobs();
		read_backpressure();
		write_backpressure();
		enable_and_tag_filter();
		idle_cycles(20);
		if (writes_seen.size() == writes_checked) begin
			$display("test passed");
			$finish;
		end else begin
			report_failure("more write lines came out than vertex jobs were sent");
		end
	end

endmodule
